/* logic/tagePkg.sv */
`default_nettype none

package tagePkg;

    // ##################################################
    // widths with a meaning

    typedef logic [31:0] pcT;       // fetch address.
    typedef logic [15:0] histT;     // global history.
    typedef logic [7:0]  baseIdxT;  // base table index.
    typedef logic [5:0]  tblIdxT;   // tagged table index.
    typedef logic [8:0]  tagT;      // partial tag.
    typedef logic [1:0]  usefulT;   // useful counter.
    typedef logic [1:0]  ctrT;      // two-bit direction counter.

    // ##################################################
    // sizes and tuning

    localparam int baseEntries = 256;
    localparam int tblEntries  = 64;

    localparam int shortHistLen = 4;
    localparam int longHistLen  = 16;

    // useful bits are cleared every 2**usefulClearBits cycles.
    localparam int usefulClearBits = 10;
    localparam int usefulClearEn   = 1;

    // counter values around the taken threshold.
    localparam ctrT ctrWeakNotTaken = 2'b01;
    localparam ctrT ctrWeakTaken    = 2'b10;
    localparam ctrT ctrMax          = 2'b11;
    localparam ctrT ctrMin          = 2'b00;

    // ##################################################
    // prediction metadata

    // which table supplied the final prediction.
    typedef enum logic [1:0] {
        base  = 2'd0,
        short = 2'd1,
        long  = 2'd2
    } providerT;

    // kept by the fetch stage and returned with the outcome.
    typedef struct packed {
        tblIdxT   shortIdx;
        tagT      shortTag;
        tblIdxT   longIdx;
        tagT      longTag;
        logic     shortHit;
        logic     longHit;
        providerT provider;
        logic     providerPred;
        logic     altPred;      // prediction without the provider.
    } predMetaT;

endpackage

`default_nettype wire

/* logic/branchCounterTable.sv */
`timescale 1ns/1ps
`default_nettype none

module branchCounterTable #(
    parameter int idxBits = 8
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               readValid,
    input  logic [idxBits-1:0] readAddr,
    output logic               taken,

    input  logic               writeEn,
    input  logic [idxBits-1:0] writeAddr,
    input  logic               writeInit,
    input  logic               writeTaken
);
    import tagePkg::*;

    ctrT counters [2**idxBits];
    ctrT current;

    assign current = counters[writeAddr];

    // read port, msb of the counter is the direction.
    always_ff @(posedge clk) begin
        if (readValid)
            taken <= counters[readAddr][1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**idxBits; i++)
                counters[i] <= ctrWeakNotTaken;
        end else if (writeEn) begin
            if (writeInit)
                counters[writeAddr] <= writeTaken ? ctrWeakTaken : ctrWeakNotTaken;
            else if (writeTaken && current != ctrMax)
                counters[writeAddr] <= current + 2'd1;
            else if (!writeTaken && current != ctrMin)
                counters[writeAddr] <= current - 2'd1;
        end
    end

    writeAddrKnown: assert property (@(posedge clk) disable iff (rst)
        writeEn |-> !$isunknown(writeAddr))
        else $error("counter write with unknown address.");

endmodule

`default_nettype wire

/* logic/tageTable.sv */
`timescale 1ns/1ps
`default_nettype none

module tageTable (
    input  logic            clk,
    input  logic            rst,

    input  logic            readValid,
    input  tagePkg::tblIdxT readAddr,
    input  tagePkg::tagT    readTag,
    output logic            hit,
    output logic            taken,

    input  logic            writeValid,
    input  tagePkg::tblIdxT writeAddr,
    input  tagePkg::tagT    writeTag,
    input  logic            writeTaken,

    input  logic            writeUpdate,
    input  logic            writeUseful,
    input  logic            writeCorrect,

    output logic            allocAvail,
    input  logic            doAlloc,
    input  logic            allocFailed
);
    import tagePkg::*;

    tagT    tags   [tblEntries];
    usefulT useful [tblEntries];
    logic   valid  [tblEntries];

    logic   hitValidQ;
    tagT    storedTagQ;
    tagT    reqTagQ;

    logic   allocAccept;
    usefulT usefulCur;

    logic [usefulClearBits-1:0] clearCnt;
    logic                       clearBit;   // which useful bit goes next.

    assign usefulCur   = useful[writeAddr];
    assign allocAvail  = (usefulCur == '0);
    assign allocAccept = writeValid && doAlloc && allocAvail;

    branchCounterTable #(
        .idxBits($clog2(tblEntries))
    ) iCounters (
        .clk       (clk),
        .rst       (rst),
        .readValid (readValid),
        .readAddr  (readAddr),
        .taken     (taken),
        .writeEn   ((writeValid && writeUpdate) || allocAccept),
        .writeAddr (writeAddr),
        .writeInit (doAlloc),
        .writeTaken(writeTaken)
    );

    // ##################################################
    // lookup

    always_ff @(posedge clk) begin
        if (rst)
            hitValidQ <= 1'b0;
        else if (readValid)
            hitValidQ <= valid[readAddr];
    end

    always_ff @(posedge clk) begin
        if (readValid) begin
            storedTagQ <= tags[readAddr];
            reqTagQ    <= readTag;
        end
    end

    assign hit = hitValidQ && (storedTagQ == reqTagQ);

    // ##################################################
    // allocation and useful tracking

    always_ff @(posedge clk) begin
        if (allocAccept)
            tags[writeAddr] <= writeTag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tblEntries; i++)
                valid[i] <= 1'b0;
        end else if (allocAccept) begin
            valid[writeAddr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clearCnt <= '0;
            clearBit <= 1'b0;
        end else begin
            clearCnt <= clearCnt + 1'b1;
            if (usefulClearEn != 0 && clearCnt == '0)
                clearBit <= !clearBit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < tblEntries; i++)
                useful[i] <= '0;
        end else begin
            if (writeValid) begin
                if (writeUpdate && writeUseful) begin
                    // provider disagreed with alt, so it earned or lost credit.
                    if (writeCorrect && usefulCur != '1)
                        useful[writeAddr] <= usefulCur + 1'b1;
                    else if (!writeCorrect && usefulCur != '0)
                        useful[writeAddr] <= usefulCur - 1'b1;
                end else if (allocFailed) begin
                    useful[writeAddr] <= usefulCur - 1'b1;  // decay on a blocked alloc.
                end
            end
            // periodic aging, low and high bit in turn.
            if (usefulClearEn != 0 && clearCnt == '0) begin
                for (int i = 0; i < tblEntries; i++)
                    useful[i][clearBit] <= 1'b0;
            end
        end
    end

    allocFailedOnUseful: assert property (@(posedge clk) disable iff (rst)
        (writeValid && allocFailed) |-> (usefulCur != '0))
        else $error("allocFailed on an entry that was free.");

    oneWriteCommand: assert property (@(posedge clk) disable iff (rst)
        writeValid |-> $onehot0({writeUpdate, doAlloc, allocFailed}))
        else $error("more than one write command to a tagged table.");

endmodule

`default_nettype wire

/* logic/globalHistory.sv */
`timescale 1ns/1ps
`default_nettype none

module globalHistory (
    input  logic            clk,
    input  logic            rst,

    input  tagePkg::pcT     pc,

    input  logic            shiftEn,
    input  logic            shiftTaken,

    output tagePkg::tblIdxT shortIdx,
    output tagePkg::tblIdxT longIdx,
    output tagePkg::tagT    shortTag,
    output tagePkg::tagT    longTag
);
    import tagePkg::*;

    histT hist;
    histT shortHist;
    histT longHist;

    // newest outcome in bit 0.
    always_ff @(posedge clk) begin
        if (rst)
            hist <= '0;
        else if (shiftEn)
            hist <= {hist[$bits(histT)-2:0], shiftTaken};
    end

    // ##################################################
    // folding

    // xor 16 history bits down to an index.
    function automatic tblIdxT foldIdx(input histT h);
        return h[5:0] ^ h[11:6] ^ {2'b00, h[15:12]};
    endfunction

    // xor down to a tag, then reverse so it differs from the index fold.
    function automatic tagT foldTag(input histT h);
        tagT folded;
        tagT reversed;
        folded = h[8:0] ^ {2'b00, h[15:9]};
        for (int i = 0; i < $bits(tagT); i++)
            reversed[i] = folded[$bits(tagT)-1-i];
        return reversed;
    endfunction

    // each table only sees its own history length.
    assign shortHist = hist & histT'({shortHistLen{1'b1}});
    assign longHist  = hist & histT'({longHistLen{1'b1}});

    // ##################################################
    // hashes

    assign shortIdx = pc[7:2] ^ foldIdx(shortHist);
    assign longIdx  = pc[7:2] ^ foldIdx(longHist);

    assign shortTag = pc[16:8] ^ foldTag(shortHist);
    assign longTag  = pc[16:8] ^ foldTag(longHist);

endmodule

`default_nettype wire

/* logic/tagePredictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tagePredictor (
    input  logic              clk,
    input  logic              rst,

    input  logic              predValid,
    input  tagePkg::pcT       predPc,

    output logic              predOutValid,
    output logic              predTaken,
    output tagePkg::predMetaT predMeta,

    input  logic              updValid,
    input  tagePkg::pcT       updPc,
    input  logic              updTaken,
    input  tagePkg::predMetaT updMeta
);
    import tagePkg::*;

    tblIdxT   shortIdx;
    tblIdxT   longIdx;
    tagT      shortTag;
    tagT      longTag;

    tblIdxT   shortIdxQ;
    tblIdxT   longIdxQ;
    tagT      shortTagQ;
    tagT      longTagQ;

    logic     baseTaken;
    logic     shortHit;
    logic     shortTaken;
    logic     longHit;
    logic     longTaken;

    providerT provider;
    logic     providerPred;
    logic     altPred;

    logic     mispred;
    logic     usefulUpd;
    logic     provCorrect;
    logic     shortAvail;
    logic     longAvail;
    logic     shortUpd;
    logic     longUpd;
    logic     shortAlloc;
    logic     longAlloc;
    logic     shortFail;
    logic     longFail;

    globalHistory iHist (
        .clk       (clk),
        .rst       (rst),
        .pc        (predPc),
        .shiftEn   (updValid),
        .shiftTaken(updTaken),
        .shortIdx  (shortIdx),
        .longIdx   (longIdx),
        .shortTag  (shortTag),
        .longTag   (longTag)
    );

    branchCounterTable #(
        .idxBits($clog2(baseEntries))
    ) iBase (
        .clk       (clk),
        .rst       (rst),
        .readValid (predValid),
        .readAddr  (baseIdxT'(predPc[9:2])),
        .taken     (baseTaken),
        .writeEn   (updValid && updMeta.provider == base),
        .writeAddr (baseIdxT'(updPc[9:2])),
        .writeInit (1'b0),
        .writeTaken(updTaken)
    );

    tageTable iShort (
        .clk         (clk),
        .rst         (rst),
        .readValid   (predValid),
        .readAddr    (shortIdx),
        .readTag     (shortTag),
        .hit         (shortHit),
        .taken       (shortTaken),
        .writeValid  (updValid),
        .writeAddr   (updMeta.shortIdx),
        .writeTag    (updMeta.shortTag),
        .writeTaken  (updTaken),
        .writeUpdate (shortUpd),
        .writeUseful (usefulUpd),
        .writeCorrect(provCorrect),
        .allocAvail  (shortAvail),
        .doAlloc     (shortAlloc),
        .allocFailed (shortFail)
    );

    tageTable iLong (
        .clk         (clk),
        .rst         (rst),
        .readValid   (predValid),
        .readAddr    (longIdx),
        .readTag     (longTag),
        .hit         (longHit),
        .taken       (longTaken),
        .writeValid  (updValid),
        .writeAddr   (updMeta.longIdx),
        .writeTag    (updMeta.longTag),
        .writeTaken  (updTaken),
        .writeUpdate (longUpd),
        .writeUseful (usefulUpd),
        .writeCorrect(provCorrect),
        .allocAvail  (longAvail),
        .doAlloc     (longAlloc),
        .allocFailed (longFail)
    );

    // ##################################################
    // predict side

    always_ff @(posedge clk) begin
        if (rst)
            predOutValid <= 1'b0;
        else
            predOutValid <= predValid;
    end

    // hashes travel alongside the table reads.
    always_ff @(posedge clk) begin
        if (predValid) begin
            shortIdxQ <= shortIdx;
            longIdxQ  <= longIdx;
            shortTagQ <= shortTag;
            longTagQ  <= longTag;
        end
    end

    // longest hit wins, alt is the next hit down.
    always_comb begin
        if (longHit) begin
            provider     = long;
            providerPred = longTaken;
            altPred      = shortHit ? shortTaken : baseTaken;
        end else if (shortHit) begin
            provider     = short;
            providerPred = shortTaken;
            altPred      = baseTaken;
        end else begin
            provider     = base;
            providerPred = baseTaken;
            altPred      = baseTaken;
        end
    end

    assign predTaken = providerPred;

    assign predMeta = '{
        shortIdx:     shortIdxQ,
        shortTag:     shortTagQ,
        longIdx:      longIdxQ,
        longTag:      longTagQ,
        shortHit:     shortHit,
        longHit:      longHit,
        provider:     provider,
        providerPred: providerPred,
        altPred:      altPred
    };

    // ##################################################
    // update side

    assign mispred     = updMeta.providerPred != updTaken;
    assign provCorrect = !mispred;
    assign usefulUpd   = updMeta.providerPred != updMeta.altPred;

    assign shortUpd = updValid && updMeta.provider == short;
    assign longUpd  = updValid && updMeta.provider == long;

    // allocate above the provider, shortest table first.
    always_comb begin
        shortAlloc = 1'b0;
        longAlloc  = 1'b0;
        shortFail  = 1'b0;
        longFail   = 1'b0;
        if (updValid && mispred) begin
            case (updMeta.provider)
                base: begin
                    if (shortAvail) begin
                        shortAlloc = 1'b1;
                    end else if (longAvail) begin
                        longAlloc = 1'b1;
                    end else begin
                        shortFail = 1'b1;
                        longFail  = 1'b1;
                    end
                end
                short: begin
                    longAlloc = longAvail;
                    longFail  = !longAvail;
                end
                default: ;  // nothing above long.
            endcase
        end
    end

    predOutFollowsPred: assert property (@(posedge clk) disable iff (rst)
        predOutValid |-> $past(predValid))
        else $error("prediction output without a request.");

endmodule

`default_nettype wire

/* tests/tagePredictorTb.sv */
`timescale 1ns/1ps
`default_nettype none

module tagePredictorTb;
    import tagePkg::*;

    logic     clk;
    logic     rst;
    logic     predValid;
    pcT       predPc;
    logic     predOutValid;
    logic     predTaken;
    predMetaT predMeta;
    logic     updValid;
    pcT       updPc;
    logic     updTaken;
    predMetaT updMeta;

    // reference model state.
    ctrT    baseM   [baseEntries];
    ctrT    ctrM    [2][tblEntries];    // index 0 short, 1 long.
    tagT    tagM    [2][tblEntries];
    logic   validM  [2][tblEntries];
    usefulT usefulM [2][tblEntries];
    histT   histM;

    predMetaT    expMeta;
    int          errors = 0;
    int          checks = 0;
    logic        timedOut = 1'b0;
    int unsigned edgeCnt;
    int unsigned syncedEdges = 0;

    tagePredictor i_dut (
        .clk         (clk),
        .rst         (rst),
        .predValid   (predValid),
        .predPc      (predPc),
        .predOutValid(predOutValid),
        .predTaken   (predTaken),
        .predMeta    (predMeta),
        .updValid    (updValid),
        .updPc       (updPc),
        .updTaken    (updTaken),
        .updMeta     (updMeta)
    );

    initial clk = 1'b0;
    always #20 clk = !clk;

    // edges since reset for the useful clear.
    always @(posedge clk) begin
        if (rst)
            edgeCnt <= 0;
        else
            edgeCnt <= edgeCnt + 1;
    end

    // ##################################################
    // reference model

    // index is pc[7:2] with each history bit folded onto bit i mod 6.
    function automatic tblIdxT hashIndex(input pcT pc, input histT h, input int len);
        tblIdxT folded;
        folded = pc[7:2];
        for (int i = 0; i < len; i++)
            folded[i % 6] = folded[i % 6] ^ h[i];
        return folded;
    endfunction

    function automatic tagT hashTag(input pcT pc, input histT h, input int len);
        tagT folded;
        tagT rev;
        folded = '0;
        for (int i = 0; i < len; i++)
            folded[i % 9] = folded[i % 9] ^ h[i];
        for (int i = 0; i < 9; i++)
            rev[i] = folded[8 - i];     // bit order reversed.
        return pc[16:8] ^ rev;
    endfunction

    function automatic logic [1:0] saturate2(input logic [1:0] c, input logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'd1;
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic predMetaT refPredict(input pcT pc);
        predMetaT m;
        logic     sTaken;
        logic     lTaken;
        logic     bTaken;
        m = '0;
        m.shortIdx = hashIndex(pc, histM, shortHistLen);
        m.longIdx  = hashIndex(pc, histM, longHistLen);
        m.shortTag = hashTag(pc, histM, shortHistLen);
        m.longTag  = hashTag(pc, histM, longHistLen);
        m.shortHit = validM[0][m.shortIdx] && tagM[0][m.shortIdx] == m.shortTag;
        m.longHit  = validM[1][m.longIdx] && tagM[1][m.longIdx] == m.longTag;
        sTaken = ctrM[0][m.shortIdx][1];
        lTaken = ctrM[1][m.longIdx][1];
        bTaken = baseM[pc[9:2]][1];
        if (m.longHit) begin
            m.provider     = long;
            m.providerPred = lTaken;
            m.altPred      = m.shortHit ? sTaken : bTaken;
        end else if (m.shortHit) begin
            m.provider     = short;
            m.providerPred = sTaken;
            m.altPred      = bTaken;
        end else begin
            m.provider     = base;
            m.providerPred = bTaken;
            m.altPred      = bTaken;
        end
        return m;
    endfunction

    task automatic allocEntry(input int t, input tblIdxT idx, input tagT tag, input logic taken);
        tagM[t][idx]   = tag;
        validM[t][idx] = 1'b1;
        ctrM[t][idx]   = taken ? 2'b10 : 2'b01;    // weak toward the outcome.
    endtask

    task automatic refUpdate(input pcT pc, input logic taken, input predMetaT m);
        logic wrong;
        wrong = m.providerPred != taken;
        case (m.provider)
            short: begin
                ctrM[0][m.shortIdx] = saturate2(ctrM[0][m.shortIdx], taken);
                if (m.providerPred != m.altPred)
                    usefulM[0][m.shortIdx] = saturate2(usefulM[0][m.shortIdx], !wrong);
            end
            long: begin
                ctrM[1][m.longIdx] = saturate2(ctrM[1][m.longIdx], taken);
                if (m.providerPred != m.altPred)
                    usefulM[1][m.longIdx] = saturate2(usefulM[1][m.longIdx], !wrong);
            end
            default: baseM[pc[9:2]] = saturate2(baseM[pc[9:2]], taken);
        endcase
        if (wrong && m.provider != long) begin
            if (m.provider == base && usefulM[0][m.shortIdx] == 2'b00) begin
                allocEntry(0, m.shortIdx, m.shortTag, taken);
            end else if (usefulM[1][m.longIdx] == 2'b00) begin
                allocEntry(1, m.longIdx, m.longTag, taken);
            end else begin
                // no room above the provider, so every table above decays.
                usefulM[1][m.longIdx] = usefulM[1][m.longIdx] - 2'd1;
                if (m.provider == base)
                    usefulM[0][m.shortIdx] = usefulM[0][m.shortIdx] - 2'd1;
            end
        end
        histM = {histM[14:0], taken};
    endtask

    // applies the periodic useful clears for every edge seen so far.
    task automatic syncClears();
        logic bitSel;
        while (syncedEdges < edgeCnt) begin
            bitSel = syncedEdges[usefulClearBits];
            if (usefulClearEn != 0 && syncedEdges % (1 << usefulClearBits) == 0) begin
                for (int t = 0; t < 2; t++)
                    for (int i = 0; i < tblEntries; i++)
                        usefulM[t][i][bitSel] = 1'b0;
            end
            syncedEdges++;
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < baseEntries; i++)
            baseM[i] = 2'b01;
        for (int t = 0; t < 2; t++)
            for (int i = 0; i < tblEntries; i++) begin
                ctrM[t][i]    = 2'b01;
                validM[t][i]  = 1'b0;
                usefulM[t][i] = 2'b00;
            end
        histM = '0;
    endtask

    // ##################################################
    // stimulus and checking

    always @(negedge clk) begin
        if (predOutValid) begin
            checks++;
            if (predTaken !== expMeta.providerPred) begin
                errors++;
                $display("error %0t: predTaken %0b, expected %0b", $time, predTaken,
                         expMeta.providerPred);
            end
            if (predMeta.provider !== expMeta.provider) begin
                errors++;
                $display("error %0t: provider %0d, expected %0d", $time, predMeta.provider,
                         expMeta.provider);
            end
            if (predMeta !== expMeta) begin
                errors++;
                $display("error %0t: predMeta %h, expected %h", $time, predMeta, expMeta);
            end
        end
    end

    // one predict, its update, then an idle cycle.
    task automatic runBranch(input pcT pc, input logic outcome);
        predMetaT m;
        int       waitCnt;
        if (!timedOut) begin
            syncClears();
            m = refPredict(pc);
            expMeta   = m;
            predValid = 1'b1;
            predPc    = pc;
            @(negedge clk);
            predValid = 1'b0;
            waitCnt = 0;
            while (!predOutValid && waitCnt < 8) begin
                @(negedge clk);
                waitCnt++;
            end
            if (!predOutValid) begin
                timedOut = 1'b1;
                $display("no prediction came back for pc %h within 8 cycles", pc);
            end else begin
                updMeta  = predMeta;    // caller hands the metadata back.
                updValid = 1'b1;
                updPc    = pc;
                updTaken = outcome;
                syncClears();
                refUpdate(pc, outcome, m);
                @(negedge clk);
                updValid = 1'b0;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        pcT          pcTbl [12];
        int          occ [12];
        int unsigned k;
        int unsigned rnd;
        logic        outcome;
        void'($urandom(44));
        rst       = 1'b1;
        predValid = 1'b0;
        predPc    = '0;
        updValid  = 1'b0;
        updPc     = '0;
        updTaken  = 1'b0;
        updMeta   = '0;
        expMeta   = '0;
        resetModel();
        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 8; i++)
            runBranch(32'h0000_1000 + 32'(i) * 32'h44, 1'b0);
        repeat (10) runBranch(32'h0000_2040, 1'b1);
        // loop exit every 8th pass needs more history than the short table.
        for (int n = 0; n < 80; n++)
            runBranch(32'h0000_3180, (n % 8) != 7);
        // same index bits, other tag, opposite pattern.
        for (int n = 0; n < 40; n++)
            runBranch(32'h0000_3380, (n % 8) == 7);
        for (int n = 0; n < 16; n++)
            runBranch(32'h0000_3180, (n % 8) != 7);

        repeat (2100) @(negedge clk);
        syncClears();   // model takes the clears of the idle time.
        for (int n = 0; n < 16; n++)
            runBranch(32'h0000_3380, (n % 8) == 7);

        for (int i = 0; i < 12; i++) begin
            pcTbl[i] = 32'h0000_4000 + 32'(i) * 32'h0000_0124;
            occ[i]   = 0;
        end
        for (int n = 0; n < 300; n++) begin
            k   = $urandom % 12;
            rnd = $urandom;
            case (k % 4)
                0: outcome = 1'b1;
                1: outcome = (occ[k] % 3) != 2;
                2: outcome = (occ[k] % 2) == 0;
                default: outcome = rnd[0];
            endcase
            occ[k]++;
            runBranch(pcTbl[k], outcome);
        end

        $display("checks %0d, errors %0d, timeout %0b", checks, errors, timedOut);
        if (errors == 0 && !timedOut)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tagePredictor.f */
logic/tagePkg.sv
logic/branchCounterTable.sv
logic/tageTable.sv
logic/globalHistory.sv
logic/tagePredictor.sv
tests/tagePredictorTb.sv

/* run.sh */
#!/bin/sh
# builds the predictor testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tagePredictorTb -f tagePredictor.f > build.log 2>&1 &&
./obj_dir/VtagePredictorTb > sim.log 2>&1 &&
! grep -q "Simulation failed" sim.log &&
grep -q "Simulation passed" sim.log &&
echo "run passed" ||
{ echo "run failed, see build.log and sim.log"; exit 1; }
